// File: include/lvds_test_cfg.svh
`ifndef LVDS_TEST_CFG_SVH
`define LVDS_TEST_CFG_SVH

// button filter
// synchronized level must hold this long before it is taken
`define LT_DEBOUNCE_CYCLES 16

// display
`define LT_SCAN_CYCLES 8      // cycles per digit before moving on

// mode counters
`define LT_MAIN_MODES 4       // wraps back to 0 after 3
`define LT_SUB_MODES 64       // full 6-bit range

// link
// start state of lane 0, lane 1 uses the inverse
// must not be 0 or all ones
`define LT_PRBS_SEED 7'h2d
`define LT_LANES 2            // data lanes on side A

`endif

// File: hdl/pad_ctrl_pkg.sv
package pad_ctrl_pkg;

  // controls for one side of the SC transceiver pair
  typedef struct packed {
    logic       sel_rx;     // receiver enable
    logic       sel_tx;     // driver enable
    logic       pd_bias;    // bias power down
    logic [1:0] idset;      // output current
    logic       hyst;       // rx hysteresis
    logic [1:0] drv_str;    // drive strength
    logic       sr;         // slew rate
    logic       puden_tx;
    logic       puden_rx;
    logic       pudpol_tx;
    logic       pudpol_rx;
    logic [1:0] test;       // test mux of the cell
  } pad_side_t;

  // whole control word, 15 + 15 + 1 = 31 bits
  typedef struct packed {
    pad_side_t a;
    pad_side_t b;
    logic      por;         // power-on reset of the cell
  } pad_ctrl_t;

  // idle word
  // por held, side B bias off, nothing else driven
  localparam pad_ctrl_t PAD_CTRL_OFF = '{
    a:   '0,
    b:   '{pd_bias: 1'b1, default: '0},
    por: 1'b1
  };

endpackage

// File: hdl/link_test_pkg.sv
package link_test_pkg;

  // mode state stepped by the buttons
  typedef logic [1:0] main_mode_t;  // 0 idles the pads
  typedef logic [5:0] sub_mode_t;   // pad settings and display select

  // counters from the link checker
  typedef struct packed {
    logic [57:0] recv_cnt;          // enabled cycles
    logic [31:0] err_a;             // lane 0 bit errors
    logic [31:0] err_b;             // lane 1 bit errors
  } link_cnt_t;

  // low three sub mode bits as seen by the display
  typedef struct packed {
    logic       err_src;            // 1 shows the error counters
    logic [1:0] slice;              // 16-bit slice index
  } disp_sel_t;

endpackage

// File: hdl/button_ctrl.sv
`include "lvds_test_cfg.svh"

module button_ctrl (
  input  logic                      clk_ibufg,
  input  logic                      rst,
  input  logic                      btn_1,
  input  logic                      btn_2,
  input  logic                      btn_3,
  output link_test_pkg::main_mode_t main_mode,
  output link_test_pkg::sub_mode_t  sub_mode,
  output logic                      clr_seq
);
  import link_test_pkg::*;

  localparam int DB_W = $clog2(`LT_DEBOUNCE_CYCLES);

  logic [2:0]      btn_raw;            // bit i is button i+1
  logic [2:0]      sync_q1;
  logic [2:0]      sync_q2;
  logic [2:0]      db_lvl;             // filtered level
  logic [2:0]      db_lvl_q;
  logic [2:0]      press;              // one cycle per accepted press
  logic [DB_W-1:0] db_cnt [3];

  assign btn_raw = {btn_3, btn_2, btn_1};

  // two flops against metastability
  always_ff @(posedge clk_ibufg) begin
    if (rst) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= btn_raw;
      sync_q2 <= sync_q1;
    end
  end

  // level flips only after a steady run of differing samples
  always_ff @(posedge clk_ibufg) begin
    if (rst) begin
      db_lvl   <= '0;
      db_lvl_q <= '0;
      for (int i = 0; i < 3; i++) db_cnt[i] <= '0;
    end else begin
      db_lvl_q <= db_lvl;
      for (int i = 0; i < 3; i++) begin
        if (sync_q2[i] == db_lvl[i]) begin
          db_cnt[i] <= '0;                 // bounce, start over
        end else if (db_cnt[i] == DB_W'(`LT_DEBOUNCE_CYCLES - 1)) begin
          db_lvl[i] <= sync_q2[i];
          db_cnt[i] <= '0;
        end else begin
          db_cnt[i] <= db_cnt[i] + 1'b1;
        end
      end
    end
  end

  assign press = db_lvl & ~db_lvl_q;       // rising edge only

  // mode counters and clear pulse
  always_ff @(posedge clk_ibufg) begin
    if (rst) begin
      main_mode <= '0;
      sub_mode  <= '0;
      clr_seq   <= 1'b0;
    end else begin
      clr_seq <= press[2];
      if (press[0])
        main_mode <= (main_mode == main_mode_t'(`LT_MAIN_MODES - 1)) ? '0
                                                                     : main_mode + 1'b1;
      if (press[1])
        sub_mode <= (sub_mode == sub_mode_t'(`LT_SUB_MODES - 1)) ? '0
                                                                 : sub_mode + 1'b1;
    end
  end

  // a press gives a single clear cycle, the filter must be low again first
  clr_one_cycle: assert property (@(posedge clk_ibufg) disable iff (rst)
    clr_seq |=> !clr_seq);

endmodule

// File: hdl/pad_cfg_regs.sv
module pad_cfg_regs (
  input  logic                      clk_ibufg,
  input  logic                      rst,
  input  link_test_pkg::main_mode_t main_mode,
  input  link_test_pkg::sub_mode_t  sub_mode,
  output pad_ctrl_pkg::pad_ctrl_t   sc_ctrl
);
  import pad_ctrl_pkg::*;

  pad_ctrl_t ctrl_nxt;

  // control word from the current modes
  always_comb begin
    ctrl_nxt = PAD_CTRL_OFF;               // side B always idle
    if (main_mode != '0) begin
      ctrl_nxt.por       = 1'b0;
      ctrl_nxt.a.sel_tx  = 1'b1;
      ctrl_nxt.a.sel_rx  = 1'b1;
      ctrl_nxt.a.drv_str = sub_mode[1:0];
      ctrl_nxt.a.idset   = sub_mode[3:2];
      ctrl_nxt.a.hyst    = sub_mode[4];
      ctrl_nxt.a.sr      = sub_mode[5];
      // cell test mode only in the last main mode
      ctrl_nxt.a.test    = (main_mode == 2'd3) ? 2'b01 : 2'b00;
    end
  end

  // one cycle behind the modes
  always_ff @(posedge clk_ibufg) begin
    if (rst)
      sc_ctrl <= PAD_CTRL_OFF;
    else
      sc_ctrl <= ctrl_nxt;
  end

  // the link must never drive while the cell is held in por
  no_tx_in_por: assert property (@(posedge clk_ibufg) disable iff (rst)
    !(sc_ctrl.por && sc_ctrl.a.sel_tx));

endmodule

// File: hdl/prbs_link.sv
`include "lvds_test_cfg.svh"

module prbs_link (
  input  logic                     clk_ibufg,
  input  logic                     rst,
  input  logic                     clr_seq,
  input  pad_ctrl_pkg::pad_ctrl_t  sc_ctrl,
  input  logic [`LT_LANES-1:0]     sca_din,
  output logic [`LT_LANES-1:0]     sca_dout,
  output link_test_pkg::link_cnt_t link_cnt
);

  logic                 en;                 // side A driving
  logic [6:0]           tx_lfsr [`LT_LANES];
  logic [6:0]           rx_sh [`LT_LANES];  // last seven received bits
  logic [`LT_LANES-1:0] pred;
  logic [`LT_LANES-1:0] mism;
  logic [2:0]           fill_cnt;
  logic                 filled;
  logic [57:0]          recv_cnt;
  logic [31:0]          err_cnt [`LT_LANES];

  assign en     = sc_ctrl.a.sel_tx;
  assign filled = (fill_cnt == 3'd7);

  // x^7 + x^6 + 1
  // tx bit is taken straight from the state so the first enabled cycle is valid
  always_comb begin
    for (int i = 0; i < `LT_LANES; i++) begin
      sca_dout[i] = tx_lfsr[i][6] ^ tx_lfsr[i][5];
      pred[i]     = rx_sh[i][6] ^ rx_sh[i][5];  // same taps on the rx side
      mism[i]     = filled & (pred[i] ^ sca_din[i]);
    end
  end

  // generators, fill counter and counters
  always_ff @(posedge clk_ibufg) begin
    if (rst || clr_seq) begin
      fill_cnt <= '0;
      recv_cnt <= '0;
      for (int i = 0; i < `LT_LANES; i++) begin
        // odd lanes start from the inverted seed
        tx_lfsr[i] <= (i % 2 == 1) ? ~`LT_PRBS_SEED : `LT_PRBS_SEED;
        err_cnt[i] <= '0;
      end
    end else if (en) begin
      if (!filled) fill_cnt <= fill_cnt + 1'b1;
      if (recv_cnt != '1) recv_cnt <= recv_cnt + 1'b1;   // saturate
      for (int i = 0; i < `LT_LANES; i++) begin
        tx_lfsr[i] <= {tx_lfsr[i][5:0], sca_dout[i]};
        if (mism[i] && err_cnt[i] != '1)
          err_cnt[i] <= err_cnt[i] + 1'b1;
      end
    end else begin
      fill_cnt <= '0;                       // refill after the next enable
    end
  end

  // receive history
  always_ff @(posedge clk_ibufg) begin
    if (en) begin
      for (int i = 0; i < `LT_LANES; i++)
        rx_sh[i] <= {rx_sh[i][5:0], sca_din[i]};
    end
  end

  // one flipped bit hits the check three times
  // as the new bit and as each of the two taps
  assign link_cnt = {recv_cnt, err_cnt[0], err_cnt[1]};

  // counters only go back down through a clear
  err_a_no_dec: assert property (@(posedge clk_ibufg) disable iff (rst)
    !clr_seq |=> link_cnt.err_a >= $past(link_cnt.err_a));
  err_b_no_dec: assert property (@(posedge clk_ibufg) disable iff (rst)
    !clr_seq |=> link_cnt.err_b >= $past(link_cnt.err_b));

endmodule

// File: hdl/handle_7seg.sv
`include "lvds_test_cfg.svh"

module handle_7seg (
  input  logic                     clk_ibufg,
  input  logic                     rst,
  input  link_test_pkg::sub_mode_t sub_mode,
  input  link_test_pkg::link_cnt_t link_cnt,
  output logic [3:0]               digit_sel,
  output logic [7:0]               digit
);
  import link_test_pkg::*;

  localparam int SCAN_W = $clog2(`LT_SCAN_CYCLES);

  logic [SCAN_W-1:0] scan_cnt;
  disp_sel_t         dsel;
  logic [63:0]       src;
  logic [15:0]       slice;
  logic [1:0]        dig_idx;
  logic [3:0]        nib;
  logic [6:0]        seg;       // active high, bit 0 is segment a

  // source and slice select
  assign dsel  = disp_sel_t'(sub_mode[2:0]);
  assign src   = dsel.err_src ? {link_cnt.err_b, link_cnt.err_a}  // err_a in the low half
                              : {6'd0, link_cnt.recv_cnt};
  assign slice = src[{dsel.slice, 4'b0000} +: 16];

  // digit scan, one low bit walks left
  always_ff @(posedge clk_ibufg) begin
    if (rst) begin
      scan_cnt  <= '0;
      digit_sel <= 4'b1110;
    end else if (scan_cnt == SCAN_W'(`LT_SCAN_CYCLES - 1)) begin
      scan_cnt  <= '0;
      digit_sel <= {digit_sel[2:0], digit_sel[3]};
    end else begin
      scan_cnt <= scan_cnt + 1'b1;
    end
  end

  // active digit position
  always_comb begin
    dig_idx = '0;
    for (int i = 0; i < 4; i++)
      if (!digit_sel[i]) dig_idx = 2'(i);
  end

  assign nib = slice[{dig_idx, 2'b00} +: 4];

  // hex font
  always_comb begin
    case (nib)
      4'h0: seg = 7'h3f;
      4'h1: seg = 7'h06;
      4'h2: seg = 7'h5b;
      4'h3: seg = 7'h4f;
      4'h4: seg = 7'h66;
      4'h5: seg = 7'h6d;
      4'h6: seg = 7'h7d;
      4'h7: seg = 7'h07;
      4'h8: seg = 7'h7f;
      4'h9: seg = 7'h6f;
      4'ha: seg = 7'h77;
      4'hb: seg = 7'h7c;   // lower case b
      4'hc: seg = 7'h39;
      4'hd: seg = 7'h5e;   // lower case d
      4'he: seg = 7'h79;
      default: seg = 7'h71;
    endcase
  end

  assign digit = {1'b1, ~seg};   // dp off, pins active low

  // one digit lit at any time
  one_digit: assert property (@(posedge clk_ibufg) disable iff (rst)
    $countones(~digit_sel) == 1);

endmodule

// File: hdl/lvds_test.sv
`include "lvds_test_cfg.svh"

module lvds_test (
  input  logic                    clk_ibufg,
  input  logic                    rst,
  input  logic                    btn_1,       // main mode step
  input  logic                    btn_2,       // sub mode step
  input  logic                    btn_3,       // counter clear
  input  logic [`LT_LANES-1:0]    sca_din,
  output logic [3:0]              digit_sel,   // active low
  output logic [7:0]              digit,       // segments a..g, dp
  output logic [`LT_LANES-1:0]    sca_dout,
  output pad_ctrl_pkg::pad_ctrl_t sc_ctrl
);
  import link_test_pkg::*;

  main_mode_t main_mode;
  sub_mode_t  sub_mode;
  logic       clr_seq;
  link_cnt_t  link_cnt;

  button_ctrl i_button_ctrl (
    .clk_ibufg (clk_ibufg),
    .rst       (rst),
    .btn_1     (btn_1),
    .btn_2     (btn_2),
    .btn_3     (btn_3),
    .main_mode (main_mode),
    .sub_mode  (sub_mode),
    .clr_seq   (clr_seq)
  );

  pad_cfg_regs i_pad_cfg_regs (
    .clk_ibufg (clk_ibufg),
    .rst       (rst),
    .main_mode (main_mode),
    .sub_mode  (sub_mode),
    .sc_ctrl   (sc_ctrl)
  );

  prbs_link i_prbs_link (
    .clk_ibufg (clk_ibufg),
    .rst       (rst),
    .clr_seq   (clr_seq),
    .sc_ctrl   (sc_ctrl),      // sel_tx of side A enables the link
    .sca_din   (sca_din),
    .sca_dout  (sca_dout),
    .link_cnt  (link_cnt)
  );

  handle_7seg i_handle_7seg (
    .clk_ibufg (clk_ibufg),
    .rst       (rst),
    .sub_mode  (sub_mode),
    .link_cnt  (link_cnt),
    .digit_sel (digit_sel),
    .digit     (digit)
  );

endmodule

// File: tests/tb_lvds_test.sv
`include "lvds_test_cfg.svh"

module tb_lvds_test;
  timeunit 1ns;
  timeprecision 100ps;
  import pad_ctrl_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int PRESS_CYCLES = 1 + 2 * (`LT_DEBOUNCE_CYCLES + 6);   // realign, high, low
  localparam int DISP_WAIT    = 5 * 4 * `LT_SCAN_CYCLES;        // one digit must show up by then
  // 40 presses, 12 display reads, 8 flips, fixed waits
  localparam int PLAN_CYCLES  = 16 + 40 * PRESS_CYCLES + 12 * DISP_WAIT + 8 * 40 + 200;

  logic                 clk_ibufg;
  logic                 rst;
  logic                 btn_1;
  logic                 btn_2;
  logic                 btn_3;
  logic [`LT_LANES-1:0] sca_din;
  logic [`LT_LANES-1:0] sca_dout;
  logic [`LT_LANES-1:0] flip_mask;   // bits to invert on the way back
  logic [3:0]           digit_sel;
  logic [7:0]           digit;
  pad_ctrl_t            sc_ctrl;

  integer seed;
  int     main_m;                   // model of the mode counters
  int     sub_m;
  int     flips_a;                  // injected flips per lane
  int     flips_b;
  int     checks;
  int     value_errs;
  int     fail_cnt;

  lvds_test DUT (
    .clk_ibufg (clk_ibufg),
    .rst       (rst),
    .btn_1     (btn_1),
    .btn_2     (btn_2),
    .btn_3     (btn_3),
    .sca_din   (sca_din),
    .digit_sel (digit_sel),
    .digit     (digit),
    .sca_dout  (sca_dout),
    .sc_ctrl   (sc_ctrl)
  );

  assign sca_din = sca_dout ^ flip_mask;   // loopback with bit-flip injection

  always #(CLK_PERIOD / 2) clk_ibufg = ~clk_ibufg;

  // pad word expected for a pair of modes
  function automatic pad_ctrl_t ctrl_model(input int mm, input int sm);
    pad_ctrl_t  c;
    logic [5:0] s;
    c = '0;
    s = 6'(sm);
    c.b.pd_bias = 1'b1;                  // side B never leaves idle
    if (mm == 0) begin
      c.por = 1'b1;
    end else begin
      c.a.sel_tx  = 1'b1;
      c.a.sel_rx  = 1'b1;
      c.a.drv_str = s[1:0];
      c.a.idset   = s[3:2];
      c.a.hyst    = s[4];
      c.a.sr      = s[5];
      c.a.test    = (mm == 3) ? 2'b01 : 2'b00;
    end
    return c;
  endfunction

  // lit segments (bit 0 is a) back to a hex value
  function automatic int seg_value(input logic [6:0] lit);
    case (lit)
      7'h3f: return 0;
      7'h06: return 1;
      7'h5b: return 2;
      7'h4f: return 3;
      7'h66: return 4;
      7'h6d: return 5;
      7'h7d: return 6;
      7'h07: return 7;
      7'h7f: return 8;
      7'h6f: return 9;
      7'h77: return 10;
      7'h7c: return 11;
      7'h39: return 12;
      7'h5e: return 13;
      7'h79: return 14;
      7'h71: return 15;
      default: return -1;                // no hex character
    endcase
  endfunction

  task automatic tick(input int n);
    repeat (n) @(posedge clk_ibufg);
    #1;                                  // drive point just after the edge
  endtask

  task automatic set_btn(input int which, input logic lvl);
    case (which)
      1: btn_1 = lvl;
      2: btn_2 = lvl;
      default: btn_3 = lvl;
    endcase
  endtask

  task automatic check_ctrl();
    pad_ctrl_t exp;
    int        waited;
    exp    = ctrl_model(main_m, sub_m);
    waited = 0;
    @(negedge clk_ibufg);
    while (sc_ctrl !== exp && waited < `LT_DEBOUNCE_CYCLES + 8) begin
      @(negedge clk_ibufg);
      waited++;
    end
    checks++;
    assert (sc_ctrl === exp) else begin
      value_errs++;
      $display("** Error: sc_ctrl = 0x%08h, expected 0x%08h (main %0d, sub %0d)",
               sc_ctrl, exp, main_m, sub_m);
    end
  endtask

  task automatic press(input int which);
    tick(1);                             // back on the drive point
    set_btn(which, 1'b1);
    tick(`LT_DEBOUNCE_CYCLES + 6);
    set_btn(which, 1'b0);
    tick(`LT_DEBOUNCE_CYCLES + 6);       // filter low again before the next edge
  endtask

  // pulse too short for the filter to accept
  task automatic glitch(input int which);
    tick(1);
    set_btn(which, 1'b1);
    tick(`LT_DEBOUNCE_CYCLES / 2);
    set_btn(which, 1'b0);
    tick(`LT_DEBOUNCE_CYCLES + 6);
    check_ctrl();
  endtask

  task automatic step_main(input int n);
    repeat (n) begin
      press(1);
      main_m = (main_m + 1) % `LT_MAIN_MODES;
      check_ctrl();
    end
  endtask

  task automatic step_sub(input int n);
    repeat (n) begin
      press(2);
      sub_m = (sub_m + 1) % `LT_SUB_MODES;
      check_ctrl();
    end
  endtask

  // collect the four scanned digits into one value
  task automatic read_display(output logic [15:0] val);
    int k;
    int waited;
    int nib;
    val = '0;
    for (k = 0; k < 4; k++) begin
      waited = 0;
      @(negedge clk_ibufg);
      while (digit_sel != ~(4'b0001 << k) && waited < DISP_WAIT) begin
        @(negedge clk_ibufg);
        waited++;
      end
      if (waited >= DISP_WAIT) begin
        fail_cnt++;
        $display("display scan never selected digit %0d", k);
      end
      nib = seg_value(~digit[6:0]);
      checks++;
      assert (nib >= 0) else begin
        value_errs++;
        $display("** Error: digit = 0x%02h, not a hex character", digit);
      end
      if (nib >= 0) val[k*4 +: 4] = 4'(nib);
    end
  endtask

  task automatic check_display(input string what, input logic [15:0] exp);
    logic [15:0] shown;
    read_display(shown);
    checks++;
    assert (shown == exp) else begin
      value_errs++;
      $display("** Error: digit (%s) = 0x%04h, expected 0x%04h", what, shown, exp);
    end
  endtask

  // isolated flips with enough clean bits after each to clear both taps
  task automatic inject_flips(input int lane, input int count);
    int n;
    int gap;
    for (n = 0; n < count; n++) begin
      gap = 10 + int'({$random(seed)} % 32'd24);
      tick(gap);
      flip_mask[lane] = 1'b1;
      tick(1);
      flip_mask[lane] = 1'b0;
    end
    tick(12);
  endtask

  one_digit_lit: assert property (@(posedge clk_ibufg) disable iff (rst)
    $countones(~digit_sel) == 1)
    else begin
      value_errs++;
      $display("** Error: digit_sel = 0x%h, exactly one low bit expected", digit_sel);
    end

  dp_dark: assert property (@(posedge clk_ibufg) disable iff (rst) digit[7])
    else begin
      value_errs++;
      $display("** Error: digit = 0x%02h, decimal point lit", digit);
    end

  side_b_idle: assert property (@(posedge clk_ibufg) disable iff (rst)
    sc_ctrl.b == ctrl_model(0, 0).b)
    else begin
      value_errs++;
      $display("** Error: sc_ctrl.b = 0x%04h, side B left idle", sc_ctrl.b);
    end

  initial begin
    logic [15:0]          shown;
    logic [15:0]          frozen;
    logic [`LT_LANES-1:0] held;
    clk_ibufg  = 1'b0;
    rst        = 1'b1;
    btn_1      = 1'b0;
    btn_2      = 1'b0;
    btn_3      = 1'b0;
    flip_mask  = '0;
    seed       = 32'hb95cb9bf;
    main_m     = 0;
    sub_m      = 0;
    flips_a    = 0;
    flips_b    = 0;
    checks     = 0;
    value_errs = 0;
    fail_cnt   = 0;
    tick(16);
    rst = 1'b0;

    // idle state after reset
    check_ctrl();
    check_display("recv_cnt slice 0", 16'h0000);

    // mode stepping with ignored glitches
    glitch(1);
    step_main(1);
    step_sub(3);
    glitch(2);
    step_main(3);                        // 2 and 3 with the test field and back to 0
    step_main(1);
    step_sub(5);                         // sub 8 shows recv_cnt slice 0

    // clean loopback
    press(3);
    tick(100);
    read_display(shown);
    checks++;
    assert (shown != 16'h0000) else begin
      value_errs++;
      $display("** Error: digit (recv_cnt slice 0) = 0x%04h, expected nonzero", shown);
    end
    step_sub(4);                         // sub 12 shows err_a
    check_display("err_a slice 0", 16'h0000);
    step_sub(2);                         // sub 14 shows err_b
    check_display("err_b slice 0", 16'h0000);

    // three errors per isolated flip
    inject_flips(0, 5);
    flips_a += 5;
    inject_flips(1, 3);
    flips_b += 3;
    check_display("err_b slice 0", 16'(3 * flips_b));
    step_sub(6);                         // sub 20 shows err_a again
    check_display("err_a slice 0", 16'(3 * flips_a));

    // clear and then stop the link
    press(3);
    check_display("err_a slice 0", 16'h0000);
    step_sub(2);
    check_display("err_b slice 0", 16'h0000);
    step_main(3);                        // back to main mode 0
    step_sub(2);                         // sub 24 shows recv_cnt slice 0
    read_display(frozen);
    held = sca_dout;
    repeat (40) begin
      @(negedge clk_ibufg);
      checks++;
      assert (sca_dout == held) else begin
        value_errs++;
        $display("** Error: sca_dout = 0x%h, expected 0x%h while idle", sca_dout, held);
      end
    end
    read_display(shown);
    checks++;
    assert (shown == frozen && shown != 16'h0000) else begin
      value_errs++;
      $display("** Error: digit (recv_cnt slice 0) = 0x%04h, expected frozen 0x%04h",
               shown, frozen);
    end

    $display("checks: %0d, value errors: %0d, other failures: %0d",
             checks, value_errs, fail_cnt);
    if (value_errs == 0 && fail_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(200 * PLAN_CYCLES * CLK_PERIOD);
    $display("watchdog expired, the test sequence did not finish in time");
    $display("checks: %0d, value errors: %0d, other failures: %0d",
             checks, value_errs, fail_cnt + 1);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: lvds_test.f
+incdir+include
hdl/pad_ctrl_pkg.sv
hdl/link_test_pkg.sv
hdl/button_ctrl.sv
hdl/pad_cfg_regs.sv
hdl/prbs_link.sv
hdl/handle_7seg.sv
hdl/lvds_test.sv
tests/tb_lvds_test.sv

// File: run_sim.sh
#!/bin/sh
# build and run the lvds_test testbench with Verilator
cd "$(dirname "$0")" || exit 1

BUILD=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f lvds_test.f --top-module tb_lvds_test \
  -Mdir "$BUILD" -o tb_lvds_test
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD/tb_lvds_test" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

# the log decides the verdict
if grep -q "STATUS: FAIL" "$LOG"; then
  echo "testbench reported failure, see $LOG"
  exit 1
fi
exit 0
